// File: src/mc_mem_pkg.sv
`default_nettype none

package mc_mem_pkg;

  // dma word and cache-side addressing
  localparam int data_width_c      = 32;
  localparam int bank_addr_width_c = 10;
  localparam int vcache_id_width_c = 3;
  localparam int ch_index_width_c  = 3;

  // dram channel address fields
  localparam int ba_width_c = 2;
  localparam int bg_width_c = 1;
  localparam int ro_width_c = 4;
  localparam int co_width_c = 3;
  localparam int bo_width_c = 2;

  localparam int ch_addr_width_c =
    ba_width_c + bg_width_c + ro_width_c + co_width_c + bo_width_c;

  // one word per address with the byte offset dropped
  localparam int dram_words_c = 2 ** (ch_addr_width_c - bo_width_c);

  // same 12 bits, two field orders
  typedef union packed {
    struct packed {
      logic [ba_width_c-1:0] ba;
      logic [bg_width_c-1:0] bg;
      logic [ro_width_c-1:0] ro;
      logic [co_width_c-1:0] co;
      logic [bo_width_c-1:0] bo;
    } cache_ord;
    struct packed {
      logic [ro_width_c-1:0] ro;
      logic [bg_width_c-1:0] bg;
      logic [ba_width_c-1:0] ba;
      logic [co_width_c-1:0] co;
      logic [bo_width_c-1:0] bo;
    } dram_ord;
  } dram_ch_addr_u;

endpackage

`default_nettype wire

// File: src/mc_tag_reset.sv
`timescale 1ns/1ps
`default_nettype none

module mc_tag_reset #(
  parameter int tag_cycles_p = 8
  , parameter int reset_depth_p = 3
) (
  input  logic clk_i
  , input  logic reset_i
  , output logic tag_done_o
  , output logic core_reset_o
);

  localparam int cnt_width_lp = $clog2(tag_cycles_p + 1);

  logic [cnt_width_lp-1:0] tag_cnt_r;
  logic tag_done_r;
  logic [reset_depth_p-1:0] reset_chain_r;

  // tag programming phase
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_cnt_r  <= '0;
      tag_done_r <= 1'b0;
    end else if (!tag_done_r) begin
      tag_cnt_r <= tag_cnt_r + cnt_width_lp'(1);
      if (tag_cnt_r == cnt_width_lp'(tag_cycles_p - 1)) begin
        tag_done_r <= 1'b1;
      end
    end
  end

  // core held in reset until done has crossed the chain
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reset_chain_r <= '1;
    end else begin
      reset_chain_r[0] <= ~tag_done_r;
      for (int i = 1; i < reset_depth_p; i++) begin
        reset_chain_r[i] <= reset_chain_r[i-1];
      end
    end
  end

  assign tag_done_o   = tag_done_r;
  assign core_reset_o = reset_chain_r[reset_depth_p-1];

  // done is sticky until the next external reset
  tag_done_sticky_a : assert property (@(posedge clk_i) disable iff (reset_i)
    tag_done_o |=> tag_done_o);

  // core reset release trails tag done by the chain depth
  core_reset_delay_a : assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(core_reset_o) |-> $past(tag_done_o, reset_depth_p));

endmodule

`default_nettype wire

// File: src/mc_dma_channel_map.sv
`timescale 1ns/1ps
`default_nettype none

module mc_dma_channel_map #(
  parameter int num_vcaches_p = 8
  , parameter int vcaches_per_channel_p = 4
) (
  input  logic clk_i
  , input  logic reset_i

  , input  logic req_v_i
  , input  logic req_write_i
  , input  logic [mc_mem_pkg::vcache_id_width_c-1:0] req_vcache_id_i
  , input  logic [mc_mem_pkg::bank_addr_width_c-1:0] req_addr_i
  , input  logic [mc_mem_pkg::data_width_c-1:0] req_data_i

  , output logic map_v_o
  , output logic map_write_o
  , output logic [mc_mem_pkg::ch_index_width_c-1:0] map_ch_o
  , output mc_mem_pkg::dram_ch_addr_u map_addr_o
  , output logic [mc_mem_pkg::data_width_c-1:0] map_data_o
);

  import mc_mem_pkg::*;

  // bits left above the bank address for the local cache index
  localparam int local_width_lp = ch_addr_width_c - bank_addr_width_c;

  logic [ch_index_width_c-1:0] ch_idx;
  logic [local_width_lp-1:0] local_idx;
  dram_ch_addr_u ch_addr;

  // vcaches_per_channel_p is a power of two, so these are shifts and masks
  assign ch_idx    = ch_index_width_c'(int'(req_vcache_id_i) / vcaches_per_channel_p);
  assign local_idx = local_width_lp'(int'(req_vcache_id_i) % vcaches_per_channel_p);
  assign ch_addr   = {local_idx, req_addr_i};

  // requests seen during core reset are dropped here
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      map_v_o <= 1'b0;
    end else begin
      map_v_o <= req_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    map_write_o <= req_write_i;
    map_ch_o    <= ch_idx;
    map_addr_o  <= ch_addr;
    map_data_o  <= req_data_i;
  end

  vcache_id_range_a : assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i |-> int'(req_vcache_id_i) < num_vcaches_p);

endmodule

`default_nettype wire

// File: src/mc_dram_addr_hash.sv
`timescale 1ns/1ps
`default_nettype none

module mc_dram_addr_hash (
  input  logic clk_i
  , input  logic reset_i

  // from channel map, cache order
  , input  logic map_v_i
  , input  logic map_write_i
  , input  logic [mc_mem_pkg::ch_index_width_c-1:0] map_ch_i
  , input  mc_mem_pkg::dram_ch_addr_u map_addr_i
  , input  logic [mc_mem_pkg::data_width_c-1:0] map_data_i

  // read done from dram, dram order
  , input  logic rd_v_i
  , input  logic [mc_mem_pkg::ch_index_width_c-1:0] rd_ch_i
  , input  mc_mem_pkg::dram_ch_addr_u rd_addr_i
  , input  logic [mc_mem_pkg::data_width_c-1:0] rd_data_i

  , output logic dram_v_o
  , output logic dram_write_o
  , output logic [mc_mem_pkg::ch_index_width_c-1:0] dram_ch_o
  , output mc_mem_pkg::dram_ch_addr_u dram_addr_o
  , output logic [mc_mem_pkg::data_width_c-1:0] dram_data_o

  , output logic resp_v_o
  , output logic [mc_mem_pkg::ch_index_width_c-1:0] resp_ch_o
  , output mc_mem_pkg::dram_ch_addr_u resp_addr_o
  , output logic [mc_mem_pkg::data_width_c-1:0] resp_data_o
);

  import mc_mem_pkg::*;

  dram_ch_addr_u req_hashed;
  dram_ch_addr_u rsp_hashed;

  ////////////////////////////////////////
  // ba-bg-ro-co-bo to ro-bg-ba-co-bo
  ////////////////////////////////////////
  always_comb begin
    req_hashed.dram_ord.ro = map_addr_i.cache_ord.ro;
    req_hashed.dram_ord.bg = map_addr_i.cache_ord.bg;
    req_hashed.dram_ord.ba = map_addr_i.cache_ord.ba;
    req_hashed.dram_ord.co = map_addr_i.cache_ord.co;
    req_hashed.dram_ord.bo = map_addr_i.cache_ord.bo;
  end

  ////////////////////////////////////////
  // and back for read done
  ////////////////////////////////////////
  always_comb begin
    rsp_hashed.cache_ord.ba = rd_addr_i.dram_ord.ba;
    rsp_hashed.cache_ord.bg = rd_addr_i.dram_ord.bg;
    rsp_hashed.cache_ord.ro = rd_addr_i.dram_ord.ro;
    rsp_hashed.cache_ord.co = rd_addr_i.dram_ord.co;
    rsp_hashed.cache_ord.bo = rd_addr_i.dram_ord.bo;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dram_v_o <= 1'b0;
      resp_v_o <= 1'b0;
    end else begin
      dram_v_o <= map_v_i;
      resp_v_o <= rd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    dram_write_o <= map_write_i;
    dram_ch_o    <= map_ch_i;
    dram_addr_o  <= req_hashed;
    dram_data_o  <= map_data_i;
    resp_ch_o    <= rd_ch_i;
    resp_addr_o  <= rsp_hashed;
    resp_data_o  <= rd_data_i;
  end

endmodule

`default_nettype wire

// File: src/mc_test_dram.sv
`timescale 1ns/1ps
`default_nettype none

module mc_test_dram #(
  parameter int num_vcaches_p = 8
  , parameter int vcaches_per_channel_p = 4
) (
  input  logic clk_i
  , input  logic reset_i

  , input  logic dram_v_i
  , input  logic dram_write_i
  , input  logic [mc_mem_pkg::ch_index_width_c-1:0] dram_ch_i
  , input  mc_mem_pkg::dram_ch_addr_u dram_addr_i
  , input  logic [mc_mem_pkg::data_width_c-1:0] dram_data_i

  , output logic rd_v_o
  , output logic [mc_mem_pkg::ch_index_width_c-1:0] rd_ch_o
  , output mc_mem_pkg::dram_ch_addr_u rd_addr_o
  , output logic [mc_mem_pkg::data_width_c-1:0] rd_data_o
);

  import mc_mem_pkg::*;

  localparam int num_channels_lp   = num_vcaches_p / vcaches_per_channel_p;
  localparam int ch_sel_width_lp   = (num_channels_lp > 1) ? $clog2(num_channels_lp) : 1;
  localparam int word_idx_width_lp = $clog2(dram_words_c);

  logic [data_width_c-1:0] mem_r [num_channels_lp][dram_words_c] = '{default: '0};

  logic [ch_sel_width_lp-1:0] ch_sel;
  logic [word_idx_width_lp-1:0] word_idx;
  logic rd_en;
  logic wr_en;

  // word index in dram order, byte offset dropped
  assign word_idx = {dram_addr_i.dram_ord.ro, dram_addr_i.dram_ord.bg,
                     dram_addr_i.dram_ord.ba, dram_addr_i.dram_ord.co};
  assign ch_sel   = ch_sel_width_lp'(dram_ch_i);
  assign rd_en    = dram_v_i & ~dram_write_i;
  assign wr_en    = dram_v_i & dram_write_i;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[ch_sel][word_idx] <= dram_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_o <= 1'b0;
    end else begin
      rd_v_o <= rd_en;
    end
  end

  // read done carries its channel and address back
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_ch_o   <= dram_ch_i;
      rd_addr_o <= dram_addr_i;
      rd_data_o <= mem_r[ch_sel][word_idx];
    end
  end

  channel_range_a : assert property (@(posedge clk_i) disable iff (reset_i)
    dram_v_i |-> int'(dram_ch_i) < num_channels_lp);

endmodule

`default_nettype wire

// File: src/mc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mc_mem_top #(
  parameter int num_vcaches_p = 8
  , parameter int vcaches_per_channel_p = 4
  , parameter int tag_cycles_p = 8
  , parameter int reset_depth_p = 3
) (
  input  logic clk_i
  , input  logic reset_i

  , input  logic req_v_i
  , input  logic req_write_i
  , input  logic [mc_mem_pkg::vcache_id_width_c-1:0] req_vcache_id_i
  , input  logic [mc_mem_pkg::bank_addr_width_c-1:0] req_addr_i
  , input  logic [mc_mem_pkg::data_width_c-1:0] req_data_i

  , output logic tag_done_o
  , output logic resp_v_o
  , output logic [mc_mem_pkg::ch_index_width_c-1:0] resp_ch_o
  , output mc_mem_pkg::dram_ch_addr_u resp_addr_o
  , output logic [mc_mem_pkg::data_width_c-1:0] resp_data_o
);

  import mc_mem_pkg::*;

  logic core_reset_lo;

  logic map_v_lo;
  logic map_write_lo;
  logic [ch_index_width_c-1:0] map_ch_lo;
  dram_ch_addr_u map_addr_lo;
  logic [data_width_c-1:0] map_data_lo;

  logic dram_v_lo;
  logic dram_write_lo;
  logic [ch_index_width_c-1:0] dram_ch_lo;
  dram_ch_addr_u dram_addr_lo;
  logic [data_width_c-1:0] dram_data_lo;

  logic rd_v_lo;
  logic [ch_index_width_c-1:0] rd_ch_lo;
  dram_ch_addr_u rd_addr_lo;
  logic [data_width_c-1:0] rd_data_lo;

  ////////////////////////////////////////
  // reset sequencing
  ////////////////////////////////////////
  mc_tag_reset #(
    .tag_cycles_p(tag_cycles_p)
    ,.reset_depth_p(reset_depth_p)
  ) tag_reset (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.tag_done_o(tag_done_o)
    ,.core_reset_o(core_reset_lo)
  );

  ////////////////////////////////////////
  // dma request path
  ////////////////////////////////////////
  mc_dma_channel_map #(
    .num_vcaches_p(num_vcaches_p)
    ,.vcaches_per_channel_p(vcaches_per_channel_p)
  ) dma_map (
    .clk_i(clk_i)
    ,.reset_i(core_reset_lo)
    ,.req_v_i(req_v_i)
    ,.req_write_i(req_write_i)
    ,.req_vcache_id_i(req_vcache_id_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.map_v_o(map_v_lo)
    ,.map_write_o(map_write_lo)
    ,.map_ch_o(map_ch_lo)
    ,.map_addr_o(map_addr_lo)
    ,.map_data_o(map_data_lo)
  );

  mc_dram_addr_hash addr_hash (
    .clk_i(clk_i)
    ,.reset_i(core_reset_lo)
    ,.map_v_i(map_v_lo)
    ,.map_write_i(map_write_lo)
    ,.map_ch_i(map_ch_lo)
    ,.map_addr_i(map_addr_lo)
    ,.map_data_i(map_data_lo)
    ,.rd_v_i(rd_v_lo)
    ,.rd_ch_i(rd_ch_lo)
    ,.rd_addr_i(rd_addr_lo)
    ,.rd_data_i(rd_data_lo)
    ,.dram_v_o(dram_v_lo)
    ,.dram_write_o(dram_write_lo)
    ,.dram_ch_o(dram_ch_lo)
    ,.dram_addr_o(dram_addr_lo)
    ,.dram_data_o(dram_data_lo)
    ,.resp_v_o(resp_v_o)
    ,.resp_ch_o(resp_ch_o)
    ,.resp_addr_o(resp_addr_o)
    ,.resp_data_o(resp_data_o)
  );

  mc_test_dram #(
    .num_vcaches_p(num_vcaches_p)
    ,.vcaches_per_channel_p(vcaches_per_channel_p)
  ) test_dram (
    .clk_i(clk_i)
    ,.reset_i(core_reset_lo)
    ,.dram_v_i(dram_v_lo)
    ,.dram_write_i(dram_write_lo)
    ,.dram_ch_i(dram_ch_lo)
    ,.dram_addr_i(dram_addr_lo)
    ,.dram_data_i(dram_data_lo)
    ,.rd_v_o(rd_v_lo)
    ,.rd_ch_o(rd_ch_lo)
    ,.rd_addr_o(rd_addr_lo)
    ,.rd_data_o(rd_data_lo)
  );

endmodule

`default_nettype wire

// File: test/tb_mc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mc_mem_top;

  import mc_mem_pkg::*;

  localparam int num_vcaches_c         = 8;
  localparam int vcaches_per_channel_c = 4;
  localparam int tag_cycles_c          = 8;
  localparam int reset_depth_c         = 3;

  localparam int num_channels_c   = num_vcaches_c / vcaches_per_channel_c;
  localparam int local_width_c    = ch_addr_width_c - bank_addr_width_c;
  localparam int reset_cycles_c   = 4;
  localparam int read_latency_c   = 4;
  localparam int early_reqs_c     = tag_cycles_c + reset_depth_c - 1;
  localparam int isolation_reqs_c = 2 * num_vcaches_c;
  localparam int random_reqs_c    = 300;
  localparam int drain_cycles_c   = read_latency_c + 2;
  localparam int timeout_c = reset_cycles_c + tag_cycles_c + reset_depth_c + 2 * early_reqs_c
                           + isolation_reqs_c + random_reqs_c + read_latency_c
                           + drain_cycles_c + 50;

  typedef struct packed {
    logic [31:0] due;
    logic [ch_index_width_c-1:0] ch;
    dram_ch_addr_u addr;
    logic [data_width_c-1:0] data;
  } exp_rd_t;

  logic clk_i;
  logic reset_i;
  logic req_v_i;
  logic req_write_i;
  logic [vcache_id_width_c-1:0] req_vcache_id_i;
  logic [bank_addr_width_c-1:0] req_addr_i;
  logic [data_width_c-1:0] req_data_i;
  logic tag_done_o;
  logic resp_v_o;
  logic [ch_index_width_c-1:0] resp_ch_o;
  dram_ch_addr_u resp_addr_o;
  logic [data_width_c-1:0] resp_data_o;

  int cycle_cnt = 0;
  int seed = 10;
  logic [data_width_c-1:0] model_mem [num_channels_c][dram_words_c];
  exp_rd_t exp_q [$];
  logic [vcache_id_width_c-1:0] early_id_q [$];
  logic [bank_addr_width_c-1:0] early_addr_q [$];

  mc_mem_top #(
    .num_vcaches_p(num_vcaches_c)
    ,.vcaches_per_channel_p(vcaches_per_channel_c)
    ,.tag_cycles_p(tag_cycles_c)
    ,.reset_depth_p(reset_depth_c)
  ) mc_mem_top_i (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.req_v_i(req_v_i)
    ,.req_write_i(req_write_i)
    ,.req_vcache_id_i(req_vcache_id_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.tag_done_o(tag_done_o)
    ,.resp_v_o(resp_v_o)
    ,.resp_ch_o(resp_ch_o)
    ,.resp_addr_o(resp_addr_o)
    ,.resp_data_o(resp_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////
  // error reporting and compares
  ////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_ch(input string name, input logic [ch_index_width_c-1:0] got,
                          input logic [ch_index_width_c-1:0] want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_addr(input string name, input dram_ch_addr_u got,
                            input dram_ch_addr_u want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_data(input string name, input logic [data_width_c-1:0] got,
                            input logic [data_width_c-1:0] want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    end
  endtask

  ////////////////////////////////////////
  // stimulus and model
  ////////////////////////////////////////
  task automatic issue_req(input logic wr, input logic [vcache_id_width_c-1:0] id,
                           input logic [bank_addr_width_c-1:0] addr,
                           input logic [data_width_c-1:0] data, input logic tracked);
    exp_rd_t e;
    int ch_n;
    int word_n;
    logic [local_width_c-1:0] local_idx;
    logic [ch_addr_width_c-1:0] addr_vec;
    @(posedge clk_i);
    req_v_i         <= 1'b1;
    req_write_i     <= wr;
    req_vcache_id_i <= id;
    req_addr_i      <= addr;
    req_data_i      <= data;
    // channel and local cache index from the vcache id
    ch_n      = int'(id) / vcaches_per_channel_c;
    local_idx = local_width_c'(int'(id) % vcaches_per_channel_c);
    addr_vec  = {local_idx, addr};
    // words only with the byte offset ignored
    word_n    = int'(addr_vec[ch_addr_width_c-1:bo_width_c]);
    if (tracked) begin
      if (wr) begin
        model_mem[ch_n][word_n] = data;
      end else begin
        e.due  = 32'(cycle_cnt + 1 + read_latency_c);
        e.ch   = ch_index_width_c'(ch_n);
        e.addr = addr_vec;
        e.data = model_mem[ch_n][word_n];
        exp_q.push_back(e);
      end
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    req_v_i <= 1'b0;
  endtask

  task automatic check_response();
    exp_rd_t e;
    if (resp_v_o) begin
      if (exp_q.size() == 0) begin
        report_failure($sformatf("response at cycle %0d with no read outstanding", cycle_cnt));
      end
      e = exp_q.pop_front();
      if (e.due != cycle_cnt) begin
        report_failure($sformatf("response at cycle %0d, expected at cycle %0d",
                                 cycle_cnt, e.due));
      end
      check_ch("resp_ch_o", resp_ch_o, e.ch);
      check_addr("resp_addr_o", resp_addr_o, e.addr);
      check_data("resp_data_o", resp_data_o, e.data);
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
      report_failure($sformatf("no response for the read due at cycle %0d", exp_q[0].due));
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (cycle_cnt > timeout_c) begin
      report_failure($sformatf("run did not finish within %0d cycles", timeout_c));
    end
    if (cycle_cnt >= 1) begin
      check_bit("tag_done_o", tag_done_o, cycle_cnt >= reset_cycles_c + tag_cycles_c);
    end
    if (cycle_cnt > reset_cycles_c) begin
      check_response();
    end
  end

  initial begin
    logic [31:0] r;
    logic wr;
    logic prev_wr;
    logic [vcache_id_width_c-1:0] id;
    logic [vcache_id_width_c-1:0] last_id;
    logic [bank_addr_width_c-1:0] addr;
    logic [bank_addr_width_c-1:0] last_addr;
    logic [data_width_c-1:0] data;

    reset_i         = 1'b1;
    req_v_i         = 1'b0;
    req_write_i     = 1'b0;
    req_vcache_id_i = '0;
    req_addr_i      = '0;
    req_data_i      = '0;
    prev_wr         = 1'b0;
    last_id         = '0;
    last_addr       = '0;
    for (int c = 0; c < num_channels_c; c++) begin
      for (int w = 0; w < dram_words_c; w++) begin
        model_mem[c][w] = '0;
      end
    end

    repeat (reset_cycles_c) @(posedge clk_i);
    reset_i <= 1'b0;

    // core still in reset so all of these are dropped
    for (int n = 0; n < early_reqs_c; n++) begin
      r    = $random(seed);
      data = $random(seed);
      wr   = ~r[31];
      id   = vcache_id_width_c'(int'(r[15:4]) % num_vcaches_c);
      addr = r[16 +: bank_addr_width_c];
      if (wr) begin
        early_id_q.push_back(id);
        early_addr_q.push_back(addr);
      end
      issue_req(wr, id, addr, data | 32'h1, 1'b0);
    end

    // dropped writes left memory at zero
    while (early_id_q.size() > 0) begin
      issue_req(1'b0, early_id_q.pop_front(), early_addr_q.pop_front(), '0, 1'b1);
    end

    ////////////////////////////////////////
    // one bank address on every vcache
    ////////////////////////////////////////
    r    = $random(seed);
    addr = r[bank_addr_width_c-1:0];
    for (int v = 0; v < num_vcaches_c; v++) begin
      data = $random(seed);
      issue_req(1'b1, vcache_id_width_c'(v), addr, data, 1'b1);
    end
    for (int v = 0; v < num_vcaches_c; v++) begin
      issue_req(1'b0, vcache_id_width_c'(v), addr, '0, 1'b1);
    end

    // random mix back to back
    for (int n = 0; n < random_reqs_c; n++) begin
      r    = $random(seed);
      data = $random(seed);
      wr   = r[0];
      id   = vcache_id_width_c'(int'(r[15:4]) % num_vcaches_c);
      addr = r[16 +: bank_addr_width_c];
      // sometimes read right behind a write to the same word
      if (prev_wr && !wr && r[2:1] == 2'b00) begin
        id   = last_id;
        addr = last_addr;
      end
      if (wr) begin
        last_id   = id;
        last_addr = addr;
      end
      prev_wr = wr;
      issue_req(wr, id, addr, data, 1'b1);
    end

    repeat (drain_cycles_c) idle_cycle();

    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d reads never got a response", exp_q.size()));
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
src/mc_mem_pkg.sv
src/mc_tag_reset.sv
src/mc_dma_channel_map.sv
src/mc_dram_addr_hash.sv
src/mc_test_dram.sv
src/mc_mem_top.sv
test/tb_mc_mem_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, pass only when the pass line shows up
verilator --binary --timing --assert --top-module tb_mc_mem_top -f sim.f \
  && ./obj_dir/Vtb_mc_mem_top | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
